// ==== design/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int DATA_W     = 16;   // register and instruction width
    localparam int PC_W       = 32;
    localparam int REG_ADDR_W = 3;    // eight registers
    localparam int SHAMT_W    = 4;
    localparam int OPCODE_W   = 5;

    // field positions, lsb of each field
    localparam int OPC_LSB   = 11;    // opcode in 15..11
    localparam int DST_LSB   = 8;     // dst in 10..8
    localparam int SRC_LSB   = 5;     // src in 7..5
    localparam int SHAMT_LSB = 0;     // shift amount in 3..0

    // codes not listed here decode as a nop
    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP  = 5'd0,
        OP_MOV  = 5'd1,
        OP_ADD  = 5'd2,
        OP_SUB  = 5'd3,
        OP_AND  = 5'd4,
        OP_OR   = 5'd5,
        OP_NOT  = 5'd6,
        OP_INC  = 5'd7,
        OP_SHL  = 5'd8,
        OP_SHR  = 5'd9,
        OP_LDM  = 5'd10,
        OP_LDD  = 5'd11,
        OP_STD  = 5'd12,
        OP_PUSH = 5'd13,
        OP_POP  = 5'd14,
        OP_OUT  = 5'd15,
        OP_IN   = 5'd16,
        OP_JZ   = 5'd17,
        OP_JMP  = 5'd18,
        OP_CALL = 5'd19,
        OP_RET  = 5'd20,
        OP_SETC = 5'd21,
        OP_CLRC = 5'd22
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_PASS = 4'd0,   // mov and everything non-arithmetic
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_NOT  = 4'd5,
        ALU_INC  = 4'd6,
        ALU_SHL  = 4'd7,
        ALU_SHR  = 4'd8
    } alu_op_e;

endpackage

`default_nettype wire

// ==== design/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    typedef enum logic [1:0] {
        WB_ALU    = 2'd0,
        WB_MEM    = 2'd1,
        WB_INPORT = 2'd2,
        WB_IMM    = 2'd3
    } wb_sel_e;

    typedef enum logic [1:0] {
        MSRC_REG   = 2'd0,
        MSRC_PC    = 2'd1,
        MSRC_FLAGS = 2'd2
    } mem_src_e;

    typedef enum logic [1:0] {
        MADDR_REG    = 2'd0,
        MADDR_SP     = 2'd1,
        MADDR_VECTOR = 2'd2   // interrupt vector slot
    } mem_addr_e;

    typedef enum logic [1:0] {
        CARRY_KEEP  = 2'd0,
        CARRY_SET   = 2'd1,
        CARRY_CLEAR = 2'd2
    } carry_e;

    // jump kinds, zero means no jump
    localparam int          JSEL_W    = 3;
    localparam logic [2:0]  JSEL_JZ   = 3'd1;
    localparam logic [2:0]  JSEL_JMP  = 3'd2;
    localparam logic [2:0]  JSEL_CALL = 3'd3;
    localparam logic [2:0]  JSEL_RET  = 3'd4;

    // all zero is a bubble
    typedef struct packed {
        logic                           reg_write;
        logic                           mem_read;
        logic                           mem_write;
        logic                           mem_pop;
        logic                           mem_push;
        logic                           flag_reg_select;
        logic                           pc_choose_memory;
        logic                           clear_instruction;
        logic [JSEL_W-1:0]              jump_sel;
        logic [isa_pkg::REG_ADDR_W-1:0] src;
        logic [isa_pkg::REG_ADDR_W-1:0] dst;
        mem_src_e                       mem_src;
        isa_pkg::alu_op_e               alu_op;
        wb_sel_e                        wb_sel;
        mem_addr_e                      mem_addr;
        carry_e                         carry_sel;
        logic                           alu_srcsel;
        logic                           outport_enable;
        logic                           inport_sel;
        logic                           flagreg_enable;
    } ctrl_word_t;

    typedef struct packed {
        logic [isa_pkg::DATA_W-1:0]     rdata1;        // dst register
        logic [isa_pkg::DATA_W-1:0]     rdata2;        // src register
        logic [isa_pkg::PC_W-1:0]       pc_plus_one;
        logic [isa_pkg::REG_ADDR_W-1:0] wb_addr;
        logic [isa_pkg::SHAMT_W-1:0]    shamt;
    } dec_data_t;

endpackage

`default_nettype wire

// ==== design/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // loads every cycle, there is no stall
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            q <= payload_t'('0);
        end else begin
            q <= d;
        end
    end

    // a flushed slot reaches execute as a bubble
    clear_gives_bubble: assert property (
        @(posedge clk) disable iff (reset)
        clear |=> (q == payload_t'('0))
    ) else $error("pipe_reg: payload not zero after clear");

endmodule

`default_nettype wire

// ==== design/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       interrupt_signal,
    input  logic [isa_pkg::DATA_W-1:0] instruction,
    output ctrl_pkg::ctrl_word_t       ctrl_next
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        INT_PUSH   = 2'd1,
        INT_VECTOR = 2'd2
    } int_state_e;

    int_state_e            state;
    int_state_e            state_next;
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] src;
    logic [REG_ADDR_W-1:0] dst;
    ctrl_word_t            table_word;

    function automatic alu_op_e alu_op_of(input opcode_e op);
        case (op)
            OP_ADD:  return ALU_ADD;
            OP_SUB:  return ALU_SUB;
            OP_AND:  return ALU_AND;
            OP_OR:   return ALU_OR;
            OP_NOT:  return ALU_NOT;
            OP_INC:  return ALU_INC;
            OP_SHL:  return ALU_SHL;
            OP_SHR:  return ALU_SHR;
            default: return ALU_PASS;
        endcase
    endfunction

    assign opcode = opcode_e'(instruction[OPC_LSB +: OPCODE_W]);
    assign src    = instruction[SRC_LSB +: REG_ADDR_W];
    assign dst    = instruction[DST_LSB +: REG_ADDR_W];

    // interrupt entry, two fixed cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            IDLE:       state_next = interrupt_signal ? INT_PUSH : IDLE;
            INT_PUSH:   state_next = INT_VECTOR;
            default:    state_next = IDLE;
        endcase
    end

    always_comb begin : decode_table
        table_word        = '0;
        table_word.src    = src;   // register numbers pass for every opcode
        table_word.dst    = dst;
        table_word.alu_op = alu_op_of(opcode);
        case (opcode)
            OP_MOV: begin
                table_word.reg_write = 1'b1;
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_INC: begin
                table_word.reg_write      = 1'b1;
                table_word.flagreg_enable = 1'b1;
            end
            OP_SHL, OP_SHR: begin
                table_word.reg_write      = 1'b1;
                table_word.flagreg_enable = 1'b1;
                table_word.alu_srcsel     = 1'b1;   // shamt as second operand
            end
            OP_LDM: begin
                table_word.reg_write = 1'b1;
                table_word.wb_sel    = WB_IMM;
            end
            OP_LDD: begin
                table_word.reg_write = 1'b1;
                table_word.mem_read  = 1'b1;
                table_word.wb_sel    = WB_MEM;
            end
            OP_STD: begin
                table_word.mem_write = 1'b1;
                table_word.mem_src   = MSRC_REG;
            end
            OP_PUSH: begin
                table_word.mem_write = 1'b1;
                table_word.mem_push  = 1'b1;
                table_word.mem_addr  = MADDR_SP;
            end
            OP_POP: begin
                table_word.reg_write = 1'b1;
                table_word.mem_read  = 1'b1;
                table_word.mem_pop   = 1'b1;
                table_word.mem_addr  = MADDR_SP;
                table_word.wb_sel    = WB_MEM;
            end
            OP_OUT: begin
                table_word.outport_enable = 1'b1;
            end
            OP_IN: begin
                table_word.reg_write  = 1'b1;
                table_word.inport_sel = 1'b1;
                table_word.wb_sel     = WB_INPORT;
            end
            OP_JZ: begin
                table_word.jump_sel = JSEL_JZ;
            end
            OP_JMP: begin
                table_word.jump_sel = JSEL_JMP;
            end
            OP_CALL: begin
                table_word.jump_sel  = JSEL_CALL;
                table_word.mem_write = 1'b1;
                table_word.mem_push  = 1'b1;
                table_word.mem_src   = MSRC_PC;   // return address
                table_word.mem_addr  = MADDR_SP;
            end
            OP_RET: begin
                table_word.jump_sel         = JSEL_RET;
                table_word.mem_read         = 1'b1;
                table_word.mem_pop          = 1'b1;
                table_word.mem_addr         = MADDR_SP;
                table_word.pc_choose_memory = 1'b1;
            end
            OP_SETC: begin
                table_word.carry_sel       = CARRY_SET;
                table_word.flag_reg_select = 1'b1;
                table_word.flagreg_enable  = 1'b1;
            end
            OP_CLRC: begin
                table_word.carry_sel       = CARRY_CLEAR;
                table_word.flag_reg_select = 1'b1;
                table_word.flagreg_enable  = 1'b1;
            end
            default: begin
                // nop and undefined codes keep the bubble
            end
        endcase
    end

    // the sequence replaces whatever instruction sits in decode
    always_comb begin : interrupt_override
        ctrl_next = table_word;
        case (state)
            INT_PUSH: begin
                ctrl_next                   = '0;
                ctrl_next.src               = src;
                ctrl_next.dst               = dst;
                ctrl_next.mem_write         = 1'b1;
                ctrl_next.mem_push          = 1'b1;
                ctrl_next.mem_src           = MSRC_PC;
                ctrl_next.mem_addr          = MADDR_SP;
                ctrl_next.clear_instruction = 1'b1;
            end
            INT_VECTOR: begin
                ctrl_next                   = '0;
                ctrl_next.src               = src;
                ctrl_next.dst               = dst;
                ctrl_next.mem_read          = 1'b1;
                ctrl_next.mem_addr          = MADDR_VECTOR;
                ctrl_next.pc_choose_memory  = 1'b1;   // pc from vector word
                ctrl_next.clear_instruction = 1'b1;
            end
            default: begin
            end
        endcase
    end

    no_mem_clash: assert property (
        @(posedge clk) disable iff (reset)
        !(ctrl_next.mem_read && ctrl_next.mem_write)
    ) else $error("control_unit: mem_read and mem_write both set");

    int_seq_length: assert property (
        @(posedge clk) disable iff (reset)
        $rose(state != IDLE) |-> ##2 (state == IDLE)
    ) else $error("control_unit: interrupt sequence not two cycles");

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           write,
    input  logic [isa_pkg::REG_ADDR_W-1:0] write_addr,
    input  logic [isa_pkg::REG_ADDR_W-1:0] read_addr1,
    input  logic [isa_pkg::REG_ADDR_W-1:0] read_addr2,
    input  logic [WIDTH-1:0]               write_data,
    output logic [WIDTH-1:0]               read_data1,
    output logic [WIDTH-1:0]               read_data2
);
    import isa_pkg::*;

    localparam int N_REGS = 2 ** REG_ADDR_W;

    logic [WIDTH-1:0] regs [N_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[write_addr] <= write_data;
        end
    end

    // no bypass path
    // same-edge read returns the old contents
    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

    write_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        write |-> !$isunknown(write_addr)
    ) else $error("reg_file: write strobe with unknown address");

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           interrupt_signal,
    input  logic [isa_pkg::DATA_W-1:0]     instruction,
    input  logic [isa_pkg::PC_W-1:0]       pc_plus_one,
    input  logic                           wb_write,
    input  logic [isa_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [isa_pkg::DATA_W-1:0]     wb_data,
    output ctrl_pkg::ctrl_word_t           ctrl,
    output ctrl_pkg::dec_data_t            data,
    output logic [isa_pkg::REG_ADDR_W-1:0] src_fetch,
    output logic [isa_pkg::REG_ADDR_W-1:0] dst_fetch
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [REG_ADDR_W-1:0] dst_field;
    logic [REG_ADDR_W-1:0] src_field;
    logic [SHAMT_W-1:0]    shamt_field;
    logic [DATA_W-1:0]     rdata1;
    logic [DATA_W-1:0]     rdata2;
    ctrl_word_t            ctrl_next;
    dec_data_t             data_next;

    assign dst_field   = instruction[DST_LSB +: REG_ADDR_W];
    assign src_field   = instruction[SRC_LSB +: REG_ADDR_W];
    assign shamt_field = instruction[SHAMT_LSB +: SHAMT_W];

    control_unit u_control (
        .clk              (clk),
        .reset            (reset),
        .interrupt_signal (interrupt_signal),
        .instruction      (instruction),
        .ctrl_next        (ctrl_next)
    );

    // port 1 on dst, port 2 on src
    reg_file #(
        .WIDTH (DATA_W)
    ) u_regs (
        .clk        (clk),
        .reset      (reset),
        .write      (wb_write),
        .write_addr (wb_addr),
        .read_addr1 (dst_field),
        .read_addr2 (src_field),
        .write_data (wb_data),
        .read_data1 (rdata1),
        .read_data2 (rdata2)
    );

    assign data_next = '{
        rdata1:      rdata1,
        rdata2:      rdata2,
        pc_plus_one: pc_plus_one,
        wb_addr:     dst_field,   // result goes back to dst
        shamt:       shamt_field
    };

    // unregistered, for hazard detection in fetch
    assign src_fetch = ctrl_next.src;
    assign dst_fetch = ctrl_next.dst;

    pipe_reg #(
        .payload_t (ctrl_word_t)
    ) u_ctrl_reg (
        .clk   (clk),
        .reset (reset),
        .clear (flush),
        .d     (ctrl_next),
        .q     (ctrl)
    );

    pipe_reg #(
        .payload_t (dec_data_t)
    ) u_data_reg (
        .clk   (clk),
        .reset (reset),
        .clear (flush),
        .d     (data_next),
        .q     (data)
    );

endmodule

`default_nettype wire

// ==== bench/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef enum logic [1:0] {
    MODEL_IDLE,
    MODEL_PUSH,
    MODEL_VECTOR
} model_state_e;

model_state_e      model_state;
logic [DATA_W-1:0] model_regs [8];
ctrl_word_t        exp_ctrl;   // what ctrl holds after the last edge
dec_data_t         exp_data;

function automatic ctrl_word_t expected_ctrl(input logic [15:0] instr);
    ctrl_word_t w;
    logic [4:0] op;
    op = instr[15:11];
    w = '0;
    w.src = instr[7:5];
    w.dst = instr[10:8];
    w.reg_write = op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_INC,
                             OP_SHL, OP_SHR, OP_LDM, OP_LDD, OP_POP, OP_IN};
    w.flagreg_enable = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_INC,
                                  OP_SHL, OP_SHR, OP_SETC, OP_CLRC};
    w.mem_read = op inside {OP_LDD, OP_POP, OP_RET};
    w.mem_write = op inside {OP_STD, OP_PUSH, OP_CALL};
    w.mem_pop = op inside {OP_POP, OP_RET};
    w.mem_push = op inside {OP_PUSH, OP_CALL};
    w.pc_choose_memory = (op == OP_RET);
    w.flag_reg_select = op inside {OP_SETC, OP_CLRC};
    w.alu_srcsel = op inside {OP_SHL, OP_SHR};   // shift amount operand
    w.outport_enable = (op == OP_OUT);
    w.inport_sel = (op == OP_IN);
    if (op inside {OP_PUSH, OP_POP, OP_CALL, OP_RET}) begin
        w.mem_addr = MADDR_SP;
    end
    if (op == OP_CALL) begin
        w.mem_src = MSRC_PC;
    end
    case (op)
        OP_LDD, OP_POP: w.wb_sel = WB_MEM;
        OP_IN:          w.wb_sel = WB_INPORT;
        OP_LDM:         w.wb_sel = WB_IMM;
        default:        w.wb_sel = WB_ALU;
    endcase
    case (op)
        OP_JZ:   w.jump_sel = JSEL_JZ;
        OP_JMP:  w.jump_sel = JSEL_JMP;
        OP_CALL: w.jump_sel = JSEL_CALL;
        OP_RET:  w.jump_sel = JSEL_RET;
        default: w.jump_sel = '0;
    endcase
    if (op == OP_SETC) w.carry_sel = CARRY_SET;
    if (op == OP_CLRC) w.carry_sel = CARRY_CLEAR;
    case (op)
        OP_ADD:  w.alu_op = ALU_ADD;
        OP_SUB:  w.alu_op = ALU_SUB;
        OP_AND:  w.alu_op = ALU_AND;
        OP_OR:   w.alu_op = ALU_OR;
        OP_NOT:  w.alu_op = ALU_NOT;
        OP_INC:  w.alu_op = ALU_INC;
        OP_SHL:  w.alu_op = ALU_SHL;
        OP_SHR:  w.alu_op = ALU_SHR;
        default: w.alu_op = ALU_PASS;
    endcase
    return w;
endfunction

// words issued by the interrupt entry, whatever sits in decode
function automatic ctrl_word_t interrupt_word(input logic vector_cycle,
                                              input logic [15:0] instr);
    ctrl_word_t w;
    w = '0;
    w.src = instr[7:5];
    w.dst = instr[10:8];
    w.clear_instruction = 1'b1;
    if (vector_cycle) begin
        w.mem_read = 1'b1;
        w.mem_addr = MADDR_VECTOR;
        w.pc_choose_memory = 1'b1;
    end else begin
        w.mem_write = 1'b1;
        w.mem_push = 1'b1;
        w.mem_src = MSRC_PC;
        w.mem_addr = MADDR_SP;
    end
    return w;
endfunction

// one rising edge with the inputs that were held before it
task automatic model_step(input logic rst, input logic flush_in, input logic intr,
                          input logic [15:0] instr, input logic [31:0] pc,
                          input logic wr, input logic [2:0] waddr,
                          input logic [15:0] wdata);
    ctrl_word_t w;
    if (rst) begin
        exp_ctrl = '0;
        exp_data = '0;
        model_state = MODEL_IDLE;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
    end else begin
        case (model_state)
            MODEL_PUSH:   w = interrupt_word(1'b0, instr);
            MODEL_VECTOR: w = interrupt_word(1'b1, instr);
            default:      w = expected_ctrl(instr);
        endcase
        exp_data.rdata1 = model_regs[instr[10:8]];   // old contents
        exp_data.rdata2 = model_regs[instr[7:5]];
        exp_data.pc_plus_one = pc;
        exp_data.wb_addr = instr[10:8];
        exp_data.shamt = instr[3:0];
        exp_ctrl = w;
        if (flush_in) begin
            exp_ctrl = '0;
            exp_data = '0;
        end
        case (model_state)
            MODEL_IDLE: model_state = intr ? MODEL_PUSH : MODEL_IDLE;
            MODEL_PUSH: model_state = MODEL_VECTOR;
            default:    model_state = MODEL_IDLE;
        endcase
        if (wr) model_regs[waddr] = wdata;
    end
endtask

`endif

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int          PERIOD       = 100;
    localparam int          RESET_CYCLES = 8;
    localparam int          TEST_CYCLES  = 2000;
    localparam logic [31:0] LFSR_SEED    = 32'h2215_6f96;
    localparam logic [31:0] LFSR_TAPS    = 32'hA300_0000;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    logic                  interrupt_signal;
    logic [DATA_W-1:0]     instruction;
    logic [PC_W-1:0]       pc_plus_one;
    logic                  wb_write;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;
    ctrl_word_t            ctrl;
    dec_data_t             data;
    logic [REG_ADDR_W-1:0] src_fetch;
    logic [REG_ADDR_W-1:0] dst_fetch;
    logic [31:0]           lfsr;
    int                    errors;
    int                    checks;

    `include "decode_model.svh"

    decode_stage UUT (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .interrupt_signal (interrupt_signal),
        .instruction      (instruction),
        .pc_plus_one      (pc_plus_one),
        .wb_write         (wb_write),
        .wb_addr          (wb_addr),
        .wb_data          (wb_data),
        .ctrl             (ctrl),
        .data             (data),
        .src_fetch        (src_fetch),
        .dst_fetch        (dst_fetch)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, actual,
                     expected);
        end
    endtask

    task automatic compare_outputs();
        check_value("ctrl.reg_write", ctrl.reg_write, exp_ctrl.reg_write);
        check_value("ctrl.mem_read", ctrl.mem_read, exp_ctrl.mem_read);
        check_value("ctrl.mem_write", ctrl.mem_write, exp_ctrl.mem_write);
        check_value("ctrl.mem_pop", ctrl.mem_pop, exp_ctrl.mem_pop);
        check_value("ctrl.mem_push", ctrl.mem_push, exp_ctrl.mem_push);
        check_value("ctrl.flag_reg_select", ctrl.flag_reg_select, exp_ctrl.flag_reg_select);
        check_value("ctrl.pc_choose_memory", ctrl.pc_choose_memory,
                    exp_ctrl.pc_choose_memory);
        check_value("ctrl.clear_instruction", ctrl.clear_instruction,
                    exp_ctrl.clear_instruction);
        check_value("ctrl.jump_sel", ctrl.jump_sel, exp_ctrl.jump_sel);
        check_value("ctrl.src", ctrl.src, exp_ctrl.src);
        check_value("ctrl.dst", ctrl.dst, exp_ctrl.dst);
        check_value("ctrl.mem_src", ctrl.mem_src, exp_ctrl.mem_src);
        check_value("ctrl.alu_op", ctrl.alu_op, exp_ctrl.alu_op);
        check_value("ctrl.wb_sel", ctrl.wb_sel, exp_ctrl.wb_sel);
        check_value("ctrl.mem_addr", ctrl.mem_addr, exp_ctrl.mem_addr);
        check_value("ctrl.carry_sel", ctrl.carry_sel, exp_ctrl.carry_sel);
        check_value("ctrl.alu_srcsel", ctrl.alu_srcsel, exp_ctrl.alu_srcsel);
        check_value("ctrl.outport_enable", ctrl.outport_enable, exp_ctrl.outport_enable);
        check_value("ctrl.inport_sel", ctrl.inport_sel, exp_ctrl.inport_sel);
        check_value("ctrl.flagreg_enable", ctrl.flagreg_enable, exp_ctrl.flagreg_enable);
        check_value("data.rdata1", data.rdata1, exp_data.rdata1);
        check_value("data.rdata2", data.rdata2, exp_data.rdata2);
        check_value("data.pc_plus_one", data.pc_plus_one, exp_data.pc_plus_one);
        check_value("data.wb_addr", data.wb_addr, exp_data.wb_addr);
        check_value("data.shamt", data.shamt, exp_data.shamt);
        // fetch ports are combinational on the current instruction
        check_value("src_fetch", src_fetch, instruction[7:5]);
        check_value("dst_fetch", dst_fetch, instruction[10:8]);
    endtask

    task automatic drive_inputs(input int t);
        logic [31:0] r;
        logic [2:0]  idx;
        idx = t[2:0];
        if (t < 8) begin
            // read each register once while all are still zero
            instruction = {5'd0, idx, ~idx, 5'd0};
            flush = 1'b0;
            interrupt_signal = 1'b0;
            wb_write = 1'b0;
        end else begin
            take_bits(16, r);
            instruction = r[15:0];
            take_bits(3, r);
            flush = (r[2:0] == 3'd0);
            take_bits(5, r);
            interrupt_signal = (r[4:0] == 5'd0) && (model_state == MODEL_IDLE);
            take_bits(1, r);
            wb_write = r[0];
            take_bits(3, r);
            wb_addr = r[2:0];
            take_bits(16, r);
            wb_data = r[15:0];
            take_bits(32, r);
            pc_plus_one = r;
        end
    endtask

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + 20) * PERIOD);
        $display("timeout: run did not finish in time, checks: %0d, errors: %0d",
                 checks, errors);
        $display("test failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        interrupt_signal = 1'b0;
        instruction = '0;
        pc_plus_one = '0;
        wb_write = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        lfsr = LFSR_SEED;
        errors = 0;
        checks = 0;
        for (int cycle = 0; cycle < RESET_CYCLES + TEST_CYCLES; cycle++) begin
            @(posedge clk);
            model_step(reset, flush, interrupt_signal, instruction, pc_plus_one,
                       wb_write, wb_addr, wb_data);
            #5;
            compare_outputs();
            if (cycle + 1 >= RESET_CYCLES) begin
                reset = 1'b0;
                drive_inputs(cycle + 1 - RESET_CYCLES);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
design/isa_pkg.sv
design/ctrl_pkg.sv
design/pipe_reg.sv
design/control_unit.sv
design/reg_file.sv
design/decode_stage.sv
bench/decode_tb.sv
